// File: src/alu_cfg_pkg.sv
package alu_cfg_pkg;

   // ~~~~~~~~~~~~~~~~~~~~
   // Datapath widths
   // ~~~~~~~~~~~~~~~~~~~~

   // Operand and result width
   localparam int DATA_W = 16;

   // Top bit index, doubles as sign bit
   localparam int DATA_MSB = DATA_W - 1;

   // Bit counter for restoring division
   localparam int CNT_W = $clog2(DATA_W);

   // ~~~~~~~~~~~~~~~~~~~~
   // Derived constants
   // ~~~~~~~~~~~~~~~~~~~~

   // Most negative operand value
   localparam logic [DATA_W-1:0] DATA_MIN = {1'b1, {(DATA_W-1){1'b0}}};

   // Last division round
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DATA_W - 1);

endpackage

// File: src/alu_types_pkg.sv
package alu_types_pkg;

   import alu_cfg_pkg::*;

   // ~~~~~~~~~~~~~~~~~~~~
   // Opcodes
   // ~~~~~~~~~~~~~~~~~~~~

   localparam int OP_W = 2;

   // Order matches strobe priority
   typedef enum logic [OP_W-1:0] {
      OP_ADD,
      OP_SUB,
      OP_MUL,
      OP_DIV
   } opcode_e;

   // ~~~~~~~~~~~~~~~~~~~~
   // Stage payloads
   // ~~~~~~~~~~~~~~~~~~~~

   // Command from capture to core
   typedef struct packed {
      opcode_e           op;
      logic [DATA_W-1:0] a;
      logic [DATA_W-1:0] b;
      logic              div_zero;
   } alu_cmd_t;

   // Result from core to output port
   typedef struct packed {
      logic [DATA_W-1:0] q;
      logic              ovf;
      logic              div_zero;
   } alu_result_t;

endpackage

// File: src/alu_cmd_capture.sv
module alu_cmd_capture
   import alu_cfg_pkg::*;
   import alu_types_pkg::*;
(
   input  logic              i_clk,
   input  logic              i_nrst,
   input  logic [DATA_W-1:0] i_a,
   input  logic [DATA_W-1:0] i_b,
   input  logic              i_add,
   input  logic              i_sub,
   input  logic              i_mul,
   input  logic              i_div,
   input  logic              i_busy,
   output alu_cmd_t          o_cmd,
   output logic              o_cmd_valid
);

   logic    any_strobe;
   logic    accept;
   logic    b_zero;
   opcode_e sel_op;

   // ~~~~~~~~~~~~~~~~~~~~
   // Strobe selection
   // ~~~~~~~~~~~~~~~~~~~~

   assign any_strobe = i_add | i_sub | i_mul | i_div;

   // A command still on its way to the core blocks as well,
   // busy from the core only shows up one cycle after it takes one
   assign accept = any_strobe & ~i_busy & ~o_cmd_valid;

   assign b_zero = (i_b == '0);

   // Fixed priority add, sub, mul, div
   always_comb begin
      if (i_add) begin
         sel_op = OP_ADD;
      end else if (i_sub) begin
         sel_op = OP_SUB;
      end else if (i_mul) begin
         sel_op = OP_MUL;
      end else begin
         sel_op = OP_DIV;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // Command register
   // ~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_cmd_valid <= 1'b0;
      end else begin
         o_cmd_valid <= accept;
      end
   end

   always_ff @(posedge i_clk) begin
      if (accept) begin
         o_cmd.op       <= sel_op;
         o_cmd.a        <= i_a;
         o_cmd.b        <= i_b;
         // Only place the divisor is tested for zero
         o_cmd.div_zero <= (sel_op == OP_DIV) && b_zero;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // Checks
   // ~~~~~~~~~~~~~~~~~~~~

   // No new command while the core is still working
   a_no_cmd_when_busy: assert property (
      @(posedge i_clk) disable iff (!i_nrst)
      $rose(o_cmd_valid) |-> !i_busy
   );

endmodule

// File: src/alu_seq_core.sv
module alu_seq_core
   import alu_cfg_pkg::*;
   import alu_types_pkg::*;
(
   input  logic        i_clk,
   input  logic        i_nrst,
   input  alu_cmd_t    i_cmd,
   input  logic        i_cmd_valid,
   output logic        o_busy,
   output alu_result_t o_res,
   output logic        o_done
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_SIGN_B,
      ST_MUL,
      ST_DIV_SHIFT,
      ST_DIV_CMP,
      ST_DIV_COUNT,
      ST_SIGN_Q
   } state_e;

   state_e            state;
   alu_cmd_t          cmd_q;
   logic              start;
   logic              take;
   logic              neg;
   logic              a_neg;
   logic              b_neg;
   logic [DATA_W-1:0] a_r;
   logic [DATA_W-1:0] b_r;
   logic [DATA_W-1:0] r_r;
   logic [DATA_W-1:0] q_r;
   logic [CNT_W-1:0]  cnt;

   logic [DATA_W-1:0] adder_a;
   logic [DATA_W-1:0] adder_b;
   logic              adder_cin;
   logic [DATA_W-1:0] adder_q;
   logic              adder_co;
   logic              adder_ovf;

   logic              mul_more;
   logic              mul_ovf;
   logic [DATA_W-1:0] mul_sum;
   logic              q_too_big;

   function automatic alu_result_t pack_res(logic [DATA_W-1:0] q, logic ovf, logic dz);
      alu_result_t res;
      // Overflow always reports zero
      res.q        = ovf ? '0 : q;
      res.ovf      = ovf;
      res.div_zero = dz;
      return res;
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~
   // Command intake
   // ~~~~~~~~~~~~~~~~~~~~

   assign take  = (state == ST_IDLE) && !start && i_cmd_valid;
   assign a_neg = cmd_q.a[DATA_MSB];
   assign b_neg = cmd_q.b[DATA_MSB];

   always_ff @(posedge i_clk) begin
      if (take) begin
         cmd_q <= i_cmd;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // Shared adder
   // ~~~~~~~~~~~~~~~~~~~~

   // Negation is ~x with carry in
   always_comb begin
      adder_a   = q_r;
      adder_b   = '0;
      adder_cin = 1'b0;
      case (state)
         ST_IDLE: begin
            case (cmd_q.op)
               OP_ADD: begin
                  adder_a = cmd_q.a;
                  adder_b = cmd_q.b;
               end
               OP_SUB: begin
                  adder_a   = cmd_q.a;
                  adder_b   = ~cmd_q.b;
                  adder_cin = 1'b1;
               end
               default: begin
                  // a first, b here only if a is positive
                  adder_a   = a_neg ? ~cmd_q.a : ~cmd_q.b;
                  adder_cin = 1'b1;
               end
            endcase
         end
         ST_SIGN_B: begin
            adder_a   = ~b_r;
            adder_cin = 1'b1;
         end
         ST_MUL: begin
            adder_a = q_r;
            adder_b = b_r;
         end
         ST_DIV_CMP: begin
            adder_a   = r_r;
            adder_b   = ~b_r;
            adder_cin = 1'b1;
         end
         ST_DIV_COUNT: begin
            adder_a   = DATA_W'(cnt);
            adder_cin = 1'b1;
         end
         ST_SIGN_Q: begin
            adder_a   = ~q_r;
            adder_cin = 1'b1;
         end
         default: begin
            adder_cin = 1'b0;
         end
      endcase
   end

   assign {adder_co, adder_q} = {1'b0, adder_a} + {1'b0, adder_b} +
                                {{DATA_W{1'b0}}, adder_cin};
   assign adder_ovf = (adder_a[DATA_MSB] == adder_b[DATA_MSB]) &&
                      (adder_q[DATA_MSB] != adder_a[DATA_MSB]);

   // Magnitudes are unsigned here, carry is the range limit
   assign mul_more  = (a_r[DATA_W-1:1] != '0);
   assign mul_sum   = a_r[0] ? adder_q : q_r;
   assign mul_ovf   = (a_r[0] && adder_co) || (b_r[DATA_MSB] && mul_more);
   // Negative side may reach DATA_MIN
   assign q_too_big = q_r[DATA_MSB] && (q_r[DATA_W-2:0] != '0);

   // ~~~~~~~~~~~~~~~~~~~~
   // Control FSM
   // ~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state  <= ST_IDLE;
         start  <= 1'b0;
         neg    <= 1'b0;
         a_r    <= '0;
         b_r    <= '0;
         r_r    <= '0;
         q_r    <= '0;
         cnt    <= '0;
         o_busy <= 1'b0;
         o_done <= 1'b0;
         o_res  <= '0;
      end else begin
         o_done <= 1'b0;
         if (take) begin
            start  <= 1'b1;
            o_busy <= ((i_cmd.op == OP_MUL) || (i_cmd.op == OP_DIV)) && !i_cmd.div_zero;
         end
         case (state)
            ST_IDLE: begin
               if (start) begin
                  start <= 1'b0;
                  neg   <= a_neg ^ b_neg;
                  if (cmd_q.div_zero) begin
                     o_res  <= pack_res('0, 1'b0, 1'b1);
                     o_done <= 1'b1;
                     o_busy <= 1'b0;
                  end else if (cmd_q.op == OP_ADD) begin
                     o_res  <= pack_res(adder_q, adder_ovf, 1'b0);
                     o_done <= 1'b1;
                  end else if (cmd_q.op == OP_SUB) begin
                     o_res  <= pack_res(adder_q, adder_ovf | (cmd_q.b == DATA_MIN), 1'b0);
                     o_done <= 1'b1;
                  end else if (adder_ovf) begin
                     // Operand at DATA_MIN has no magnitude
                     o_res  <= pack_res('0, 1'b1, 1'b0);
                     o_done <= 1'b1;
                     o_busy <= 1'b0;
                  end else begin
                     a_r <= a_neg ? adder_q : cmd_q.a;
                     b_r <= (b_neg && !a_neg) ? adder_q : cmd_q.b;
                     r_r <= '0;
                     q_r <= '0;
                     cnt <= '0;
                     if (a_neg && b_neg) begin
                        state <= ST_SIGN_B;
                     end else begin
                        state <= (cmd_q.op == OP_MUL) ? ST_MUL : ST_DIV_SHIFT;
                     end
                  end
               end
            end
            ST_SIGN_B: begin
               if (adder_ovf) begin
                  o_res  <= pack_res('0, 1'b1, 1'b0);
                  o_done <= 1'b1;
                  o_busy <= 1'b0;
                  state  <= ST_IDLE;
               end else begin
                  b_r   <= adder_q;
                  state <= (cmd_q.op == OP_MUL) ? ST_MUL : ST_DIV_SHIFT;
               end
            end
            ST_MUL: begin
               a_r <= a_r >> 1;
               b_r <= b_r << 1;
               if (mul_ovf) begin
                  o_res  <= pack_res('0, 1'b1, 1'b0);
                  o_done <= 1'b1;
                  o_busy <= 1'b0;
                  state  <= ST_IDLE;
               end else begin
                  q_r <= mul_sum;
                  if (!mul_more && neg) begin
                     state <= ST_SIGN_Q;
                  end else if (!mul_more) begin
                     o_res  <= pack_res(mul_sum, mul_sum[DATA_MSB], 1'b0);
                     o_done <= 1'b1;
                     o_busy <= 1'b0;
                     state  <= ST_IDLE;
                  end
               end
            end
            ST_DIV_SHIFT: begin
               r_r   <= {r_r[DATA_W-2:0], a_r[DATA_MSB]};
               a_r   <= a_r << 1;
               state <= ST_DIV_CMP;
            end
            ST_DIV_CMP: begin
               // Carry out means r >= b, keep the difference
               if (adder_co) begin
                  r_r <= adder_q;
               end
               q_r   <= {q_r[DATA_W-2:0], adder_co};
               state <= ST_DIV_COUNT;
            end
            ST_DIV_COUNT: begin
               if (cnt != CNT_LAST) begin
                  cnt   <= adder_q[CNT_W-1:0];
                  state <= ST_DIV_SHIFT;
               end else if (neg) begin
                  state <= ST_SIGN_Q;
               end else begin
                  o_res  <= pack_res(q_r, 1'b0, 1'b0);
                  o_done <= 1'b1;
                  o_busy <= 1'b0;
                  state  <= ST_IDLE;
               end
            end
            ST_SIGN_Q: begin
               o_res  <= pack_res(adder_q, q_too_big, 1'b0);
               o_done <= 1'b1;
               o_busy <= 1'b0;
               state  <= ST_IDLE;
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // Checks
   // ~~~~~~~~~~~~~~~~~~~~

   a_done_single: assert property (
      @(posedge i_clk) disable iff (!i_nrst)
      o_done |=> !o_done
   );

   // Busy only ends with a result
   a_busy_ends_done: assert property (
      @(posedge i_clk) disable iff (!i_nrst)
      $fell(o_busy) |-> o_done
   );

endmodule

// File: src/alu_result_port.sv
module alu_result_port
   import alu_cfg_pkg::*;
   import alu_types_pkg::*;
(
   input  logic              i_clk,
   input  logic              i_nrst,
   input  alu_result_t       i_res,
   input  logic              i_done,
   input  logic              i_clr_flags,
   output logic [DATA_W-1:0] o_q,
   output logic              o_ovf,
   output logic              o_div_zero,
   output logic              o_valid,
   output logic              o_sticky_ovf,
   output logic              o_sticky_div_zero
);

   logic set_ovf;
   logic set_div_zero;

   assign set_ovf      = i_done & i_res.ovf;
   assign set_div_zero = i_done & i_res.div_zero;

   // ~~~~~~~~~~~~~~~~~~~~
   // Result registers
   // ~~~~~~~~~~~~~~~~~~~~

   // Held until the next result
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_valid    <= 1'b0;
         o_q        <= '0;
         o_ovf      <= 1'b0;
         o_div_zero <= 1'b0;
      end else begin
         o_valid <= i_done;
         if (i_done) begin
            o_q        <= i_res.q;
            o_ovf      <= i_res.ovf;
            o_div_zero <= i_res.div_zero;
         end
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // Sticky flags
   // ~~~~~~~~~~~~~~~~~~~~

   // Set beats clear in the same cycle
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_sticky_ovf      <= 1'b0;
         o_sticky_div_zero <= 1'b0;
      end else begin
         o_sticky_ovf      <= set_ovf | (o_sticky_ovf & ~i_clr_flags);
         o_sticky_div_zero <= set_div_zero | (o_sticky_div_zero & ~i_clr_flags);
      end
   end

   a_valid_single: assert property (
      @(posedge i_clk) disable iff (!i_nrst)
      o_valid |=> !o_valid
   );

endmodule

// File: src/alu_unit_top.sv
module alu_unit_top
   import alu_cfg_pkg::*;
   import alu_types_pkg::*;
(
   input  logic              i_clk,
   input  logic              i_nrst,
   input  logic [DATA_W-1:0] i_a,
   input  logic [DATA_W-1:0] i_b,
   input  logic              i_add,
   input  logic              i_sub,
   input  logic              i_mul,
   input  logic              i_div,
   input  logic              i_clr_flags,
   output logic [DATA_W-1:0] o_q,
   output logic              o_ovf,
   output logic              o_div_zero,
   output logic              o_valid,
   output logic              o_busy,
   output logic              o_sticky_ovf,
   output logic              o_sticky_div_zero
);

   alu_cmd_t    cmd;
   logic        cmd_valid;
   alu_result_t res;
   logic        done;

   // Strobes in, one command out
   alu_cmd_capture u_capture (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_a         (i_a),
      .i_b         (i_b),
      .i_add       (i_add),
      .i_sub       (i_sub),
      .i_mul       (i_mul),
      .i_div       (i_div),
      .i_busy      (o_busy),
      .o_cmd       (cmd),
      .o_cmd_valid (cmd_valid)
   );

   alu_seq_core u_core (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_cmd       (cmd),
      .i_cmd_valid (cmd_valid),
      .o_busy      (o_busy),
      .o_res       (res),
      .o_done      (done)
   );

   alu_result_port u_result (
      .i_clk             (i_clk),
      .i_nrst            (i_nrst),
      .i_res             (res),
      .i_done            (done),
      .i_clr_flags       (i_clr_flags),
      .o_q               (o_q),
      .o_ovf             (o_ovf),
      .o_div_zero        (o_div_zero),
      .o_valid           (o_valid),
      .o_sticky_ovf      (o_sticky_ovf),
      .o_sticky_div_zero (o_sticky_div_zero)
   );

endmodule

// File: sim/alu_ref_model.svh
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Reference arithmetic
// ~~~~~~~~~~~~~~~~~~~~

// Signed value of a data word
function automatic int as_int(logic [DATA_W-1:0] w);
   return int'($signed(w));
endfunction

// True when v survives a round trip through one data word
function automatic logic fits_word(int v);
   return v == int'($signed(DATA_W'(v)));
endfunction

function automatic logic is_min(logic [DATA_W-1:0] w);
   return as_int(w) == -(2 ** (DATA_W - 1));
endfunction

// Overflow forces q to zero
function automatic alu_result_t build_expected(int v, logic ovf, logic dz);
   alu_result_t r;
   r.q        = ovf ? '0 : DATA_W'(v);
   r.ovf      = ovf;
   r.div_zero = dz;
   return r;
endfunction

function automatic alu_result_t add_expected(logic [DATA_W-1:0] x, logic [DATA_W-1:0] y);
   int s;
   s = as_int(x) + as_int(y);
   return build_expected(s, !fits_word(s), 1'b0);
endfunction

function automatic alu_result_t sub_expected(logic [DATA_W-1:0] x, logic [DATA_W-1:0] y);
   int d;
   d = as_int(x) - as_int(y);
   return build_expected(d, is_min(y) || !fits_word(d), 1'b0);
endfunction

function automatic alu_result_t mul_expected(logic [DATA_W-1:0] x, logic [DATA_W-1:0] y);
   int p;
   p = as_int(x) * as_int(y);
   return build_expected(p, is_min(x) || is_min(y) || !fits_word(p), 1'b0);
endfunction

// Integer division truncates toward zero
function automatic alu_result_t div_expected(logic [DATA_W-1:0] x, logic [DATA_W-1:0] y);
   if (y == '0) begin
      return build_expected(0, 1'b0, 1'b1);
   end
   return build_expected(as_int(x) / as_int(y), is_min(x) || is_min(y), 1'b0);
endfunction

`endif

// File: sim/alu_unit_tb.sv
module alu_unit_tb
   import alu_cfg_pkg::*;
   import alu_types_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   logic              clk;
   logic              nrst;
   logic [DATA_W-1:0] a;
   logic [DATA_W-1:0] b;
   logic              add;
   logic              sub;
   logic              mul;
   logic              div;
   logic              clr_flags;
   logic [DATA_W-1:0] q;
   logic              ovf;
   logic              div_zero;
   logic              valid;
   logic              busy;
   logic              sticky_ovf;
   logic              sticky_div_zero;

   // Sticky state the outputs should show
   logic              exp_sticky_ovf;
   logic              exp_sticky_dz;

   `include "alu_ref_model.svh"

   alu_unit_top DUT (
      .i_clk             (clk),
      .i_nrst            (nrst),
      .i_a               (a),
      .i_b               (b),
      .i_add             (add),
      .i_sub             (sub),
      .i_mul             (mul),
      .i_div             (div),
      .i_clr_flags       (clr_flags),
      .o_q               (q),
      .o_ovf             (ovf),
      .o_div_zero        (div_zero),
      .o_valid           (valid),
      .o_busy            (busy),
      .o_sticky_ovf      (sticky_ovf),
      .o_sticky_div_zero (sticky_div_zero)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // Helpers
   // ~~~~~~~~~~~~~~~~~~~~

   task automatic stop_on_error(string msg);
      $display("%s", msg);
      $display("Errors found");
      $fatal(1, "stopped at first error");
   endtask

   task automatic compare_value(string name, string what, logic [DATA_W-1:0] want,
                                logic [DATA_W-1:0] got);
      assert (got === want)
      else stop_on_error($sformatf("mismatch %s %s: expected %h, actual %h",
                                   name, what, want, got));
   endtask

   function automatic logic [DATA_W-1:0] rand_operand(logic narrow);
      return narrow ? DATA_W'($signed(8'($urandom))) : DATA_W'($urandom);
   endfunction

   // Called on a falling edge, returns on one
   task automatic wait_idle(string name, int limit);
      int n;
      n = 0;
      while (busy) begin
         @(negedge clk);
         n++;
         if (n > limit) stop_on_error($sformatf("%s: o_busy never went low", name));
      end
   endtask

   task automatic no_extra_valid(string name, int cycles);
      repeat (cycles) begin
         @(negedge clk);
         assert (!valid)
         else stop_on_error($sformatf("%s: unexpected extra o_valid", name));
      end
   endtask

   // Strobe order is add, sub, mul, div from the top bit down
   task automatic issue_cmd(string name, logic [3:0] stb, logic [DATA_W-1:0] va,
                            logic [DATA_W-1:0] vb, alu_result_t want, logic fixed);
      int lat;
      wait_idle(name, 200);
      a = va;
      b = vb;
      {add, sub, mul, div} = stb;
      @(negedge clk);
      {add, sub, mul, div} = '0;
      lat = 0;
      while (!valid) begin
         assert (!(fixed && busy))
         else stop_on_error($sformatf("%s: o_busy rose on a one-step command", name));
         @(negedge clk);
         lat++;
         if (lat > 200) stop_on_error($sformatf("%s: timeout waiting for o_valid", name));
      end
      compare_value(name, "q", want.q, q);
      compare_value(name, "ovf", DATA_W'(want.ovf), DATA_W'(ovf));
      compare_value(name, "div_zero", DATA_W'(want.div_zero), DATA_W'(div_zero));
      if (fixed) begin
         compare_value(name, "latency", DATA_W'(3), DATA_W'(lat));
      end
      exp_sticky_ovf = exp_sticky_ovf | want.ovf;
      exp_sticky_dz  = exp_sticky_dz | want.div_zero;
      compare_value(name, "sticky_ovf", DATA_W'(exp_sticky_ovf), DATA_W'(sticky_ovf));
      compare_value(name, "sticky_div_zero", DATA_W'(exp_sticky_dz), DATA_W'(sticky_div_zero));
      @(negedge clk);
      assert (!valid)
      else stop_on_error($sformatf("%s: o_valid longer than one cycle", name));
   endtask

   task automatic check_op(string name, opcode_e op, logic [DATA_W-1:0] va,
                           logic [DATA_W-1:0] vb);
      alu_result_t want;
      logic [3:0]  stb;
      logic        fixed;
      case (op)
         OP_ADD:  want = add_expected(va, vb);
         OP_SUB:  want = sub_expected(va, vb);
         OP_MUL:  want = mul_expected(va, vb);
         default: want = div_expected(va, vb);
      endcase
      stb   = 4'b1000 >> op;
      fixed = (op == OP_ADD) || (op == OP_SUB) || ((op == OP_DIV) && (vb == '0));
      issue_cmd(name, stb, va, vb, want, fixed);
   endtask

   task automatic random_ops(string name, opcode_e op, int count, logic narrow);
      for (int i = 0; i < count; i++) begin
         check_op($sformatf("%s random %0d", name, i), op, rand_operand(narrow),
                  rand_operand(narrow));
      end
   endtask

   task automatic clear_flags(string name);
      wait_idle(name, 200);
      clr_flags = 1'b1;
      @(negedge clk);
      clr_flags = 1'b0;
      exp_sticky_ovf = 1'b0;
      exp_sticky_dz  = 1'b0;
      compare_value(name, "sticky_ovf", '0, DATA_W'(sticky_ovf));
      compare_value(name, "sticky_div_zero", '0, DATA_W'(sticky_div_zero));
   endtask

   // ~~~~~~~~~~~~~~~~~~~~
   // Directed tests
   // ~~~~~~~~~~~~~~~~~~~~

   task automatic check_reset_state();
      compare_value("reset", "valid", '0, DATA_W'(valid));
      compare_value("reset", "busy", '0, DATA_W'(busy));
      compare_value("reset", "sticky_ovf", '0, DATA_W'(sticky_ovf));
      compare_value("reset", "sticky_div_zero", '0, DATA_W'(sticky_div_zero));
   endtask

   task automatic add_sub_cases();
      check_op("add zero", OP_ADD, 16'h0000, 16'h0000);
      check_op("add max plus one", OP_ADD, 16'h7fff, 16'h0001);
      check_op("add min minus one", OP_ADD, 16'h8000, 16'hffff);
      check_op("add min twice", OP_ADD, 16'h8000, 16'h8000);
      check_op("add opposite", OP_ADD, 16'h1234, 16'hedcc);
      check_op("sub min", OP_SUB, 16'h0000, 16'h8000);
      check_op("sub minus one min", OP_SUB, 16'hffff, 16'h8000);
      check_op("sub from min", OP_SUB, 16'h8000, 16'h0001);
      check_op("sub max minus neg", OP_SUB, 16'h7fff, 16'hffff);
      check_op("sub small", OP_SUB, 16'h0005, 16'h0007);
      random_ops("add", OP_ADD, 20, 1'b0);
      random_ops("sub", OP_SUB, 20, 1'b0);
   endtask

   task automatic mul_cases();
      check_op("mul pos pos", OP_MUL, 16'h0003, 16'h0005);
      check_op("mul neg pos", OP_MUL, 16'hfffd, 16'h0005);
      check_op("mul pos neg", OP_MUL, 16'h0003, 16'hfffb);
      check_op("mul neg neg", OP_MUL, 16'hfffd, 16'hfffb);
      check_op("mul zero neg", OP_MUL, 16'h0000, 16'hfff9);
      check_op("mul large fit", OP_MUL, 16'h00b5, 16'h00b5);
      check_op("mul large ovf", OP_MUL, 16'h00b6, 16'h00b5);
      check_op("mul min exact", OP_MUL, 16'hff00, 16'h0080);
      check_op("mul past max", OP_MUL, 16'h0100, 16'h0080);
      check_op("mul max by one", OP_MUL, 16'h7fff, 16'h0001);
      check_op("mul min a", OP_MUL, 16'h8000, 16'h0001);
      check_op("mul min b", OP_MUL, 16'h0001, 16'h8000);
      check_op("mul neg by min", OP_MUL, 16'hffff, 16'h8000);
      random_ops("mul small", OP_MUL, 20, 1'b1);
      random_ops("mul wide", OP_MUL, 10, 1'b0);
   endtask

   task automatic div_cases();
      check_op("div pos pos", OP_DIV, 16'h0007, 16'h0002);
      check_op("div neg pos", OP_DIV, 16'hfff9, 16'h0002);
      check_op("div pos neg", OP_DIV, 16'h0007, 16'hfffe);
      check_op("div neg neg", OP_DIV, 16'hfff9, 16'hfffe);
      check_op("div zero dividend", OP_DIV, 16'h0000, 16'h0005);
      check_op("div one by max", OP_DIV, 16'h0001, 16'h7fff);
      check_op("div max by minus one", OP_DIV, 16'h7fff, 16'hffff);
      check_op("div min a", OP_DIV, 16'h8000, 16'h0001);
      check_op("div min b", OP_DIV, 16'h0005, 16'h8000);
      check_op("div by zero", OP_DIV, 16'h0009, 16'h0000);
      check_op("div min by zero", OP_DIV, 16'h8000, 16'h0000);
      random_ops("div wide", OP_DIV, 20, 1'b0);
      random_ops("div small", OP_DIV, 10, 1'b1);
   endtask

   task automatic priority_cases();
      issue_cmd("priority all", 4'b1111, 16'h0003, 16'h0005,
                add_expected(16'h0003, 16'h0005), 1'b1);
      no_extra_valid("priority all", 20);
      issue_cmd("priority sub", 4'b0111, 16'h0003, 16'h0005,
                sub_expected(16'h0003, 16'h0005), 1'b1);
      no_extra_valid("priority sub", 20);
      issue_cmd("priority mul", 4'b0011, 16'hfffd, 16'h0005,
                mul_expected(16'hfffd, 16'h0005), 1'b0);
      no_extra_valid("priority mul", 20);
   endtask

   // An add strobe during a long multiply must vanish
   task automatic busy_drop_case();
      alu_result_t want;
      int          n;
      want = mul_expected(16'h7fff, 16'h0001);
      wait_idle("busy drop", 200);
      a   = 16'h7fff;
      b   = 16'h0001;
      mul = 1'b1;
      @(negedge clk);
      mul = 1'b0;
      n   = 0;
      while (!busy) begin
         @(negedge clk);
         n++;
         if (n > 200) stop_on_error("busy drop: o_busy never went high");
      end
      a   = 16'h0002;
      b   = 16'h0003;
      add = 1'b1;
      @(negedge clk);
      add = 1'b0;
      n   = 0;
      while (!valid) begin
         @(negedge clk);
         n++;
         if (n > 200) stop_on_error("busy drop: timeout waiting for o_valid");
      end
      compare_value("busy drop", "q", want.q, q);
      compare_value("busy drop", "ovf", DATA_W'(want.ovf), DATA_W'(ovf));
      no_extra_valid("busy drop", 30);
   endtask

   task automatic sticky_flag_cases();
      clear_flags("sticky clear start");
      check_op("sticky ovf set", OP_ADD, 16'h7fff, 16'h0001);
      check_op("sticky div zero set", OP_DIV, 16'h0009, 16'h0000);
      check_op("sticky clean add", OP_ADD, 16'h0001, 16'h0002);
      check_op("sticky clean div", OP_DIV, 16'h0009, 16'h0003);
      clear_flags("sticky clear end");
      check_op("sticky after clear", OP_SUB, 16'h0004, 16'h0001);
   endtask

   // ~~~~~~~~~~~~~~~~~~~~
   // Main sequence
   // ~~~~~~~~~~~~~~~~~~~~

   initial begin
      void'($urandom(43321));
      nrst           = 1'b0;
      a              = '0;
      b              = '0;
      add            = 1'b0;
      sub            = 1'b0;
      mul            = 1'b0;
      div            = 1'b0;
      clr_flags      = 1'b0;
      exp_sticky_ovf = 1'b0;
      exp_sticky_dz  = 1'b0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      nrst = 1'b1;
      @(negedge clk);
      check_reset_state();
      add_sub_cases();
      mul_cases();
      div_cases();
      priority_cases();
      busy_drop_case();
      sticky_flag_cases();
      $display("No errors");
      $finish;
   end

endmodule

// File: alu_unit_top.f
+incdir+sim
src/alu_cfg_pkg.sv
src/alu_types_pkg.sv
src/alu_cmd_capture.sv
src/alu_seq_core.sv
src/alu_result_port.sv
src/alu_unit_top.sv
sim/alu_unit_tb.sv

// File: Makefile
VERILATOR  := verilator
TOP        := alu_unit_tb
RTL_TOP    := alu_unit_top
FILELIST   := alu_unit_top.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := Errors found
PASS_MSG   := No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation FAILED, no pass line"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
